// File: rtl/divsqrt_op_pkg.sv
package divsqrt_op_pkg;

  // ----------------------------------------------------------------------
  // Operation codes
  // ----------------------------------------------------------------------
  // Codes 2 and 3 are reserved, they run a square root and flag nv
  typedef enum logic [1:0] {
    OP_DIV   = 2'd0,
    OP_SQRT  = 2'd1,
    OP_RSVD2 = 2'd2,
    OP_RSVD3 = 2'd3
  } op_e;

  // ----------------------------------------------------------------------
  // Status flags
  // ----------------------------------------------------------------------
  localparam int unsigned STATUS_W = 2;

  // Bit positions inside the status word
  localparam int unsigned STATUS_DZ = 0;
  localparam int unsigned STATUS_NV = 1;

  // bit 0 divide by zero, bit 1 invalid operation code
  typedef logic [STATUS_W-1:0] status_t;

endpackage

// File: rtl/divsqrt_cfg_pkg.sv
package divsqrt_cfg_pkg;

  // ----------------------------------------------------------------------
  // Datapath widths
  // ----------------------------------------------------------------------
  localparam int unsigned OPERAND_W = 16;
  localparam int unsigned TAG_W     = 4;

  // Operand and result word
  typedef logic [OPERAND_W-1:0] operand_t;
  // Tag that follows an operation through the unit
  typedef logic [TAG_W-1:0]     tag_t;

  // ----------------------------------------------------------------------
  // Iteration counts, one result bit per cycle
  // ----------------------------------------------------------------------
  localparam int unsigned DIV_ITERS  = 16;
  localparam int unsigned SQRT_ITERS = 8;
  localparam int unsigned ITER_CNT_W = 5;

  typedef logic [ITER_CNT_W-1:0] iter_cnt_t;

  // Stage buses: a, b, op, tag in, then result, status, tag out
  localparam int unsigned IN_STAGE_W  = 2 * OPERAND_W + $bits(divsqrt_op_pkg::op_e) + TAG_W;
  localparam int unsigned OUT_STAGE_W = OPERAND_W + $bits(divsqrt_op_pkg::status_t) + TAG_W;

endpackage

// File: rtl/divsqrt_core_if.sv
interface divsqrt_core_if;

  // Control to core
  logic                      start_div;
  logic                      start_sqrt;
  divsqrt_cfg_pkg::operand_t operand_a;
  divsqrt_cfg_pkg::operand_t operand_b;
  logic                      kill;

  // Core back to control and hold
  divsqrt_cfg_pkg::operand_t result;
  divsqrt_op_pkg::status_t   status;
  logic                      ready;
  // Single cycle, result and status only valid here
  logic                      done;

  // Control side issues strobes, watches ready and done
  modport ctrl_mp (
    output start_div, start_sqrt, operand_a, operand_b, kill,
    input  ready, done
  );

  // Iterative engine
  modport core_mp (
    input  start_div, start_sqrt, operand_a, operand_b, kill,
    output result, status, ready, done
  );

  // Hold register only samples the finished result
  modport hold_mp (
    input result, status, done
  );

endinterface

// File: rtl/divsqrt_pipe_stage.sv
module divsqrt_pipe_stage #(
  parameter int unsigned DATA_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  // Upstream side
  input  logic              valid_i,
  input  logic [DATA_W-1:0] data_i,
  output logic              ready_o,
  // Downstream side
  input  logic              ready_i,
  output logic              valid_o,
  output logic [DATA_W-1:0] data_o
);

  logic              valid_q;
  logic [DATA_W-1:0] data_q;
  logic              load;

  // Advance when downstream takes our item or the slot is empty
  assign ready_o = ready_i | ~valid_q;

  // Data register only moves for a real item
  assign load = ready_o & valid_i;

  // Valid bit, flush wins over any load
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// File: rtl/divsqrt_ctrl.sv
module divsqrt_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // From input stage
  input  logic                      in_valid_i,
  input  divsqrt_cfg_pkg::operand_t operand_a_i,
  input  divsqrt_cfg_pkg::operand_t operand_b_i,
  input  divsqrt_op_pkg::op_e       op_i,
  input  divsqrt_cfg_pkg::tag_t     tag_i,
  output logic                      in_ready_o,
  // Towards output stage
  input  logic                      out_ready_i,
  output logic                      out_valid_o,
  output logic                      busy_o,
  output divsqrt_cfg_pkg::tag_t     tag_o,
  output logic                      nv_o,
  // Core handshake
  divsqrt_core_if.ctrl_mp           core
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e                state_q;
  state_e                state_d;
  logic                  in_ready;
  logic                  op_starting;
  divsqrt_cfg_pkg::tag_t tag_q;
  logic                  nv_q;

  // ----------------------------------------------------------------------
  // Operation decode and start strobes
  // ----------------------------------------------------------------------
  // Anything that is not a divide runs a square root
  assign core.start_div  = in_valid_i & (op_i == divsqrt_op_pkg::OP_DIV) & in_ready & ~flush_i;
  assign core.start_sqrt = in_valid_i & (op_i != divsqrt_op_pkg::OP_DIV) & in_ready & ~flush_i;
  assign core.operand_a  = operand_a_i;
  assign core.operand_b  = operand_b_i;
  assign core.kill       = flush_i;

  assign op_starting = core.start_div | core.start_sqrt;

  // Tag and invalid flag ride along with the running operation
  always_ff @(posedge clk_i) begin
    if (op_starting) begin
      tag_q <= tag_i;
      nv_q  <= (op_i != divsqrt_op_pkg::OP_DIV) && (op_i != divsqrt_op_pkg::OP_SQRT);
    end
  end

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_comb begin
    in_ready    = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;
    unique case (state_q)
      // Waiting for work
      IDLE: begin
        in_ready = core.ready;
        if (in_valid_i && core.ready) begin
          state_d = BUSY;
        end
      end
      // Core iterating
      BUSY: begin
        busy_o = 1'b1;
        if (core.done) begin
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            // Result gone, back-to-back start is allowed
            state_d  = IDLE;
            in_ready = core.ready;
            if (in_valid_i && core.ready) begin
              state_d = BUSY;
            end
          end else begin
            state_d = HOLD;
          end
        end
      end
      // Result parked, waiting on downstream
      HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = IDLE;
          if (in_valid_i && core.ready) begin
            in_ready = 1'b1;
            state_d  = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush cancels everything in flight
    if (flush_i) begin
      busy_o      = 1'b0;
      out_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign in_ready_o = in_ready;
  assign tag_o      = tag_q;
  assign nv_o       = nv_q;

endmodule

// File: rtl/divsqrt_iter_core.sv
module divsqrt_iter_core (
  input  logic            clk_i,
  input  logic            rst_n_i,
  divsqrt_core_if.core_mp core
);

  localparam int unsigned W = divsqrt_cfg_pkg::OPERAND_W;

  // Control state
  logic                       running_q;
  logic                       sqrt_q;
  divsqrt_cfg_pkg::iter_cnt_t cnt_q;
  logic                       last;
  logic                       start;
  logic                       step;

  // Datapath
  divsqrt_cfg_pkg::operand_t rem_q;
  divsqrt_cfg_pkg::operand_t shreg_q;
  divsqrt_cfg_pkg::operand_t root_q;
  divsqrt_cfg_pkg::operand_t den_q;
  logic                      dz_q;
  logic [W:0]                partial;
  logic [W:0]                subtrahend;
  logic [W+1:0]              diff;
  logic                      take;

  assign start = core.start_div | core.start_sqrt;
  assign last  = running_q && (cnt_q == '0);
  // One iteration per cycle until the counter runs out
  assign step  = running_q && (cnt_q != '0);

  // ----------------------------------------------------------------------
  // Iteration control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
    end else if (core.kill) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
    end else if (start) begin
      running_q <= 1'b1;
      cnt_q     <= core.start_div ? divsqrt_cfg_pkg::iter_cnt_t'(divsqrt_cfg_pkg::DIV_ITERS)
                                  : divsqrt_cfg_pkg::iter_cnt_t'(divsqrt_cfg_pkg::SQRT_ITERS);
    end else if (last) begin
      running_q <= 1'b0;
    end else if (step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Shared restoring step
  // ----------------------------------------------------------------------
  always_comb begin
    if (sqrt_q) begin
      // Two radicand bits come down against a trial of 4*root + 1
      partial    = {rem_q[W-2:0], shreg_q[W-1:W-2]};
      subtrahend = {root_q[W-2:0], 2'b01};
    end else begin
      // Bring down one dividend bit
      partial    = {rem_q[W-1:0], shreg_q[W-1]};
      subtrahend = {1'b0, den_q};
    end
    diff = {1'b0, partial} - {1'b0, subtrahend};
    // No borrow means the trial fits
    take = ~diff[W+1];
  end

  // Payload registers load on start and shift per step
  always_ff @(posedge clk_i) begin
    if (start) begin
      sqrt_q  <= core.start_sqrt;
      rem_q   <= '0;
      shreg_q <= core.operand_a;
      root_q  <= '0;
      den_q   <= core.operand_b;
      // Zero divisor falls out as all ones quotient
      dz_q    <= core.start_div && (core.operand_b == '0);
    end else if (step) begin
      // Remainder stays below the divisor or 2*root + 1, so W bits hold it
      rem_q <= take ? diff[W-1:0] : partial[W-1:0];
      if (sqrt_q) begin
        shreg_q <= {shreg_q[W-3:0], 2'b00};
        root_q  <= {root_q[W-2:0], take};
      end else begin
        shreg_q <= {shreg_q[W-2:0], take};
      end
    end
  end

  // ----------------------------------------------------------------------
  // Result side
  // ----------------------------------------------------------------------
  always_comb begin
    core.status                            = '0;
    core.status[divsqrt_op_pkg::STATUS_DZ] = dz_q;
  end

  assign core.result = sqrt_q ? root_q : shreg_q;
  assign core.done   = last;
  // Free again in the done cycle
  assign core.ready  = ~running_q | last;

endmodule

// File: rtl/divsqrt_result_hold.sv
module divsqrt_result_hold (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        flush_i,
  input  logic                        out_ready_i,
  input  divsqrt_cfg_pkg::tag_t       tag_i,
  input  logic                        nv_i,
  output divsqrt_cfg_pkg::operand_t   result_o,
  output divsqrt_op_pkg::status_t     status_o,
  output divsqrt_cfg_pkg::tag_t       tag_o,
  divsqrt_core_if.hold_mp             core
);

  logic                      hold_en;
  logic                      held_valid_q;
  divsqrt_cfg_pkg::operand_t held_result_q;
  divsqrt_op_pkg::status_t   held_status_q;

  // Park the result if downstream cannot take it in the done cycle
  assign hold_en = core.done & ~out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      held_valid_q <= 1'b0;
    end else if (flush_i) begin
      held_valid_q <= 1'b0;
    end else if (hold_en) begin
      held_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      // Transfer out of HOLD
      held_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_result_q <= core.result;
      held_status_q <= core.status;
    end
  end

  // ----------------------------------------------------------------------
  // Output select, held copy first
  // ----------------------------------------------------------------------
  always_comb begin
    result_o                            = held_valid_q ? held_result_q : core.result;
    status_o                            = held_valid_q ? held_status_q : core.status;
    status_o[divsqrt_op_pkg::STATUS_NV] = nv_i;
  end

  // Tag captured by control stays put until the transfer
  assign tag_o = tag_i;

endmodule

// File: rtl/divsqrt_top.sv
module divsqrt_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Operation in
  input  divsqrt_cfg_pkg::operand_t operand_a_i,
  input  divsqrt_cfg_pkg::operand_t operand_b_i,
  input  divsqrt_op_pkg::op_e       op_i,
  input  divsqrt_cfg_pkg::tag_t     tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      flush_i,
  // Result out
  output divsqrt_cfg_pkg::operand_t result_o,
  output divsqrt_op_pkg::status_t   status_o,
  output divsqrt_cfg_pkg::tag_t     tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  // Input stage bus
  logic [divsqrt_cfg_pkg::IN_STAGE_W-1:0]   in_data;
  logic                                     in_valid_q;
  logic                                     in_ready_q;
  divsqrt_cfg_pkg::operand_t                in_a;
  divsqrt_cfg_pkg::operand_t                in_b;
  logic [$bits(divsqrt_op_pkg::op_e)-1:0]   in_op;
  divsqrt_cfg_pkg::tag_t                    in_tag;

  // Control and hold outputs
  logic                                     ctrl_out_valid;
  logic                                     ctrl_busy;
  divsqrt_cfg_pkg::tag_t                    ctrl_tag;
  logic                                     ctrl_nv;
  logic                                     out_stage_ready;
  divsqrt_cfg_pkg::operand_t                hold_result;
  divsqrt_op_pkg::status_t                  hold_status;
  divsqrt_cfg_pkg::tag_t                    hold_tag;
  logic [divsqrt_cfg_pkg::OUT_STAGE_W-1:0]  out_data;

  divsqrt_core_if u_core_if ();

  // ----------------------------------------------------------------------
  // Input register stage
  // ----------------------------------------------------------------------
  divsqrt_pipe_stage #(
    .DATA_W (divsqrt_cfg_pkg::IN_STAGE_W)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .data_i  ({operand_a_i, operand_b_i, op_i, tag_i}),
    .ready_o (in_ready_o),
    .ready_i (in_ready_q),
    .valid_o (in_valid_q),
    .data_o  (in_data)
  );

  assign {in_a, in_b, in_op, in_tag} = in_data;

  divsqrt_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_q),
    .operand_a_i (in_a),
    .operand_b_i (in_b),
    .op_i        (divsqrt_op_pkg::op_e'(in_op)),
    .tag_i       (in_tag),
    .in_ready_o  (in_ready_q),
    .out_ready_i (out_stage_ready),
    .out_valid_o (ctrl_out_valid),
    .busy_o      (ctrl_busy),
    .tag_o       (ctrl_tag),
    .nv_o        (ctrl_nv),
    .core        (u_core_if.ctrl_mp)
  );

  divsqrt_iter_core u_iter_core (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .core    (u_core_if.core_mp)
  );

  divsqrt_result_hold u_result_hold (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .out_ready_i (out_stage_ready),
    .tag_i       (ctrl_tag),
    .nv_i        (ctrl_nv),
    .result_o    (hold_result),
    .status_o    (hold_status),
    .tag_o       (hold_tag),
    .core        (u_core_if.hold_mp)
  );

  // ----------------------------------------------------------------------
  // Output register stage
  // ----------------------------------------------------------------------
  divsqrt_pipe_stage #(
    .DATA_W (divsqrt_cfg_pkg::OUT_STAGE_W)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (ctrl_out_valid),
    .data_i  ({hold_result, hold_status, hold_tag}),
    .ready_o (out_stage_ready),
    .ready_i (out_ready_i),
    .valid_o (out_valid_o),
    .data_o  (out_data)
  );

  assign {result_o, status_o, tag_o} = out_data;

  // Anything valid in either stage or in the core counts as in flight
  assign busy_o = in_valid_q | ctrl_busy | out_valid_o;

endmodule

// File: include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: flush, operand a, operand b, op code, tag, expected result, expected status
// Status bit 0 is dz, bit 1 is nv
// A row with flush set is started, then flushed, and gives no output

typedef struct packed {
  logic                      flush;
  divsqrt_cfg_pkg::operand_t a;
  divsqrt_cfg_pkg::operand_t b;
  logic [1:0]                op;
  divsqrt_cfg_pkg::tag_t     tag;
  divsqrt_cfg_pkg::operand_t exp_result;
  divsqrt_op_pkg::status_t   exp_status;
} vector_t;

localparam int NUM_VECTORS = 25;

localparam vector_t VECTORS [NUM_VECTORS] = '{
  // ----------------------------------------------------------------------
  // Division
  // ----------------------------------------------------------------------
  '{1'b0, 16'd0,     16'd7,     2'd0, 4'h0, 16'd0,     2'b00},
  '{1'b0, 16'd100,   16'd7,     2'd0, 4'h1, 16'd14,    2'b00},
  '{1'b0, 16'd65535, 16'd1,     2'd0, 4'h2, 16'd65535, 2'b00},
  '{1'b0, 16'd65535, 16'd65535, 2'd0, 4'h3, 16'd1,     2'b00},
  '{1'b0, 16'd1234,  16'd1,     2'd0, 4'h4, 16'd1234,  2'b00},
  '{1'b0, 16'd50000, 16'd3,     2'd0, 4'h5, 16'd16666, 2'b00},
  '{1'b0, 16'd65535, 16'd256,   2'd0, 4'h6, 16'd255,   2'b00},
  '{1'b0, 16'd5,     16'd9,     2'd0, 4'h7, 16'd0,     2'b00},
  '{1'b0, 16'd12345, 16'd123,   2'd0, 4'h8, 16'd100,   2'b00},
  // Zero divisor, quotient of all ones
  '{1'b0, 16'd42,    16'd0,     2'd0, 4'h9, 16'd65535, 2'b01},
  '{1'b0, 16'd0,     16'd0,     2'd0, 4'ha, 16'd65535, 2'b01},
  // ----------------------------------------------------------------------
  // Square root, operand b is junk on purpose
  // ----------------------------------------------------------------------
  '{1'b0, 16'd0,     16'd77,    2'd1, 4'hb, 16'd0,     2'b00},
  '{1'b0, 16'd1,     16'd0,     2'd1, 4'hc, 16'd1,     2'b00},
  '{1'b0, 16'd144,   16'd3,     2'd1, 4'hd, 16'd12,    2'b00},
  '{1'b0, 16'd65535, 16'd1,     2'd1, 4'he, 16'd255,   2'b00},
  '{1'b0, 16'd65025, 16'd9,     2'd1, 4'hf, 16'd255,   2'b00},
  '{1'b0, 16'd1000,  16'd0,     2'd1, 4'h0, 16'd31,    2'b00},
  '{1'b0, 16'd2,     16'd5,     2'd1, 4'h1, 16'd1,     2'b00},
  '{1'b0, 16'd16384, 16'd4,     2'd1, 4'h2, 16'd128,   2'b00},
  // Reserved codes run a square root with nv
  '{1'b0, 16'd81,    16'd5,     2'd2, 4'h3, 16'd9,     2'b10},
  '{1'b0, 16'd99,    16'd0,     2'd3, 4'h4, 16'd9,     2'b10},
  // ----------------------------------------------------------------------
  // Flushed operation, then a normal one
  // ----------------------------------------------------------------------
  '{1'b1, 16'd1000,  16'd3,     2'd0, 4'h5, 16'd333,   2'b00},
  '{1'b0, 16'd1000,  16'd3,     2'd0, 4'h6, 16'd333,   2'b00},
  '{1'b1, 16'd4000,  16'd0,     2'd1, 4'h7, 16'd63,    2'b00},
  '{1'b0, 16'd4000,  16'd0,     2'd1, 4'h8, 16'd63,    2'b00}
};

`endif

// File: testbench/tb_divsqrt.sv
module tb_divsqrt;

  `include "tb_vectors.svh"

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int FLUSH_DELAY    = 3;
  localparam int STALL_MIN      = 20;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * 40 + 200;

  logic                      clk_i;
  logic                      rst_n_i;
  divsqrt_cfg_pkg::operand_t operand_a_i;
  divsqrt_cfg_pkg::operand_t operand_b_i;
  divsqrt_op_pkg::op_e       op_i;
  divsqrt_cfg_pkg::tag_t     tag_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic                      flush_i;
  divsqrt_cfg_pkg::operand_t result_o;
  divsqrt_op_pkg::status_t   status_o;
  divsqrt_cfg_pkg::tag_t     tag_o;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic                      busy_o;

  int errors;
  int checked;
  int cycles;
  // Row indices of results still owed by the DUT in arrival order
  int exp_q [$];

  // Snapshot of a stalled output
  logic                      stall_seen;
  divsqrt_cfg_pkg::operand_t stall_result;
  divsqrt_op_pkg::status_t   stall_status;
  divsqrt_cfg_pkg::tag_t     stall_tag;

  divsqrt_top u_divsqrt_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic log_error(input string msg);
    errors = errors + 1;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  // ----------------------------------------------------------------------
  // Driver
  // ----------------------------------------------------------------------
  // Holds the row on the inputs until the input stage takes it
  task automatic issue_op(input int idx);
    logic taken;
    taken       = 1'b0;
    in_valid_i  = 1'b1;
    operand_a_i = VECTORS[idx].a;
    operand_b_i = VECTORS[idx].b;
    op_i        = divsqrt_op_pkg::op_e'(VECTORS[idx].op);
    tag_i       = VECTORS[idx].tag;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      if (taken && !VECTORS[idx].flush) begin
        exp_q.push_back(idx);
      end
      @(posedge clk_i);
      #1;
    end
    in_valid_i = 1'b0;
  endtask

  // Wait until no result is owed and the unit is idle
  task automatic wait_drained;
    @(negedge clk_i);
    while (exp_q.size() != 0 || out_valid_o || busy_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic flush_op(input int idx);
    wait_drained();
    @(posedge clk_i);
    #1;
    issue_op(idx);
    repeat (FLUSH_DELAY) @(posedge clk_i);
    #1;
    if (!busy_o) begin
      log_error($sformatf("row %0d busy_o low before flush", idx));
    end
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    @(negedge clk_i);
    if (busy_o !== 1'b0) begin
      log_error($sformatf("row %0d busy_o high after flush", idx));
    end
    if (out_valid_o !== 1'b0) begin
      log_error($sformatf("row %0d out_valid_o high after flush", idx));
    end
    @(posedge clk_i);
    #1;
  endtask

  // Downstream back-pressure with occasional long stalls
  initial begin
    int stall_left;
    stall_left  = 0;
    out_ready_i = 1'b0;
    void'($urandom(52));
    forever begin
      @(posedge clk_i);
      #1;
      if (stall_left > 0) begin
        out_ready_i = 1'b0;
        stall_left  = stall_left - 1;
      end else if (($urandom % 32) == 0) begin
        // Longer than a divide so a finished result parks in the hold register
        out_ready_i = 1'b0;
        stall_left  = STALL_MIN + ($urandom % 8);
      end else begin
        out_ready_i = (($urandom % 3) != 0);
      end
    end
  end

  initial begin
    errors      = 0;
    checked     = 0;
    stall_seen  = 1'b0;
    rst_n_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = divsqrt_op_pkg::OP_DIV;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Idle state right out of reset
    @(negedge clk_i);
    if (out_valid_o !== 1'b0) begin
      log_error("out_valid_o high after reset");
    end
    if (busy_o !== 1'b0) begin
      log_error("busy_o high after reset");
    end
    if (in_ready_o !== 1'b1) begin
      log_error("in_ready_o low after reset");
    end
    @(posedge clk_i);
    #1;

    for (int i = 0; i < NUM_VECTORS; i++) begin
      if (VECTORS[i].flush) begin
        flush_op(i);
      end else begin
        issue_op(i);
      end
    end

    // Let stray outputs show up before closing
    wait_drained();
    repeat (10) @(negedge clk_i);
    $display("Summary: %0d results checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // ----------------------------------------------------------------------
  // Monitor
  // ----------------------------------------------------------------------
  task automatic check_result;
    int idx;
    if (exp_q.size() == 0) begin
      log_error($sformatf("unexpected output with tag %h", tag_o));
    end else begin
      idx     = exp_q.pop_front();
      checked = checked + 1;
      if (result_o !== VECTORS[idx].exp_result) begin
        log_error($sformatf("row %0d result %h, expected %h",
                            idx, result_o, VECTORS[idx].exp_result));
      end
      if (status_o !== VECTORS[idx].exp_status) begin
        log_error($sformatf("row %0d status %b, expected %b",
                            idx, status_o, VECTORS[idx].exp_status));
      end
      if (tag_o !== VECTORS[idx].tag) begin
        log_error($sformatf("row %0d tag %h, expected %h", idx, tag_o, VECTORS[idx].tag));
      end
    end
  endtask

  // Output side is sampled at the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (out_valid_o) begin
        if (stall_seen && (result_o !== stall_result || status_o !== stall_status ||
                           tag_o !== stall_tag)) begin
          log_error("output changed while stalled");
        end
        if (out_ready_i) begin
          stall_seen = 1'b0;
          check_result();
        end else begin
          stall_seen   = 1'b1;
          stall_result = result_o;
          stall_status = status_o;
          stall_tag    = tag_o;
        end
      end else if (stall_seen) begin
        log_error("out_valid_o dropped before transfer");
        stall_seen = 1'b0;
      end
    end
  end

  // Timeout
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
      $display("Summary: %0d results checked, %0d errors", checked, errors);
      $display("Regression failed");
      $finish;
    end
  end

  initial cycles = 0;

endmodule

// File: filelist.f
+incdir+include
rtl/divsqrt_op_pkg.sv
rtl/divsqrt_cfg_pkg.sv
rtl/divsqrt_core_if.sv
rtl/divsqrt_pipe_stage.sv
rtl/divsqrt_ctrl.sv
rtl/divsqrt_iter_core.sv
rtl/divsqrt_result_hold.sv
rtl/divsqrt_top.sv
testbench/tb_divsqrt.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the divide/square-root testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module tb_divsqrt \
  -f filelist.f \
  --Mdir obj_dir \
  -o sim_divsqrt

./obj_dir/sim_divsqrt | tee sim.log

if grep -qx "Regression passed" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
